/* Makefile */
# Verilator build and run of the face detector testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_face_detect
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/face_ref.svh */
// reference model of the cascade evaluator
// also fills the image and cascade arrays of the testbench
`ifndef FACE_REF_SVH
`define FACE_REF_SVH

// rgb565 word to 8-bit gray
function automatic int gray_of(input logic [15:0] px);
  int r;
  int g;
  int b;
  r = int'(px[15:11]);
  g = int'(px[10:5]);
  b = int'(px[4:0]);
  return (r * 76 + g * 150 + b * 30) >> 8;
endfunction

// gray of the pixel at one node offset from the centre
function automatic int node_gray(input int crow, input int ccol, input int size,
                                 input logic signed [7:0] dr, input logic signed [7:0] dc);
  int prow;
  int pcol;
  prow = (crow + int'(dr) * size) >>> 8;
  pcol = (ccol + int'(dc) * size) >>> 8;
  return gray_of(img_mem[prow * img_cols + pcol]);
endfunction

function automatic bit window_inside(input window_t w);
  int crow;
  int ccol;
  int half;
  crow = int'(w.row) * 256;
  ccol = int'(w.col) * 256;
  half = int'(w.size) * 128;  // half the window in 1/256 pixel units
  if (crow - half < 0 || crow + half > img_rows * 256 - 1) return 1'b0;
  if (ccol - half < 0 || ccol + half > img_cols * 256 - 1) return 1'b0;
  return 1'b1;
endfunction

function automatic result_t ref_eval(input window_t w);
  result_t res;
  conf_t   conf;
  conf_t   thr;
  tcode_t  code;
  int      crow;
  int      ccol;
  int      size;
  int      base;
  int      idx;
  int      ga;
  int      gb;
  int      t;
  int      lvl;
  res.detected   = 1'b0;
  res.confidence = '0;
  if (!window_inside(w)) return res;
  crow = int'(w.row) * 256;
  ccol = int'(w.col) * 256;
  size = int'(w.size);
  conf = '0;
  thr  = '0;
  for (t = 0; t < n_trees; t++) begin
    base = t * tree_stride;
    idx  = 1;
    for (lvl = 0; lvl < tree_depth; lvl++) begin
      code = tcode_t'(casc_mem[base + idx - 1]);
      ga   = node_gray(crow, ccol, size, code.r1, code.c1);
      gb   = node_gray(crow, ccol, size, code.r2, code.c2);
      idx  = (ga <= gb) ? 2 * idx + 1 : 2 * idx;
    end
    conf = conf + conf_t'(casc_mem[base + lut_base + idx - 64]);
    thr  = conf_t'(casc_mem[base + thr_base]);
    if (conf <= thr) return res;  // early reject
  end
  res.detected   = 1'b1;
  res.confidence = conf - thr;
  return res;
endfunction

task automatic fill_image();
  for (int a = 0; a < (1 << pix_aw); a++) img_mem[a] = 16'($random(seed));
endtask

// random node codes, leaves drifting upward, thresholds mostly negative
task automatic fill_cascade();
  int t;
  int k;
  for (t = 0; t < n_trees; t++) begin
    for (k = 0; k < lut_base; k++) casc_mem[t * tree_stride + k] = $random(seed);
    for (k = lut_base; k < thr_base; k++) begin
      casc_mem[t * tree_stride + k] = ($random(seed) % 4096) + 512;
    end
    casc_mem[t * tree_stride + thr_base] = ($random(seed) % 3000) - 2500;
  end
endtask

task automatic set_thresholds(input conf_t value);
  for (int t = 0; t < n_trees; t++) casc_mem[t * tree_stride + thr_base] = value;
endtask

`endif

/* bench/tb_face_detect.sv */
// testbench for the face detector cascade evaluator
// memory models, directed and random windows checked against a reference model
`default_nettype none

module tb_face_detect import face_pkg::*; ();

  localparam int n_windows      = 45;
  localparam int timeout_cycles = n_windows * n_trees * 60 + 1000;
  localparam int reset_cycles   = 10;

  logic               ACLK;
  logic               ARESETN;
  logic               start;
  window_t            window;
  logic               busy;
  logic               done;
  result_t            result;
  logic               pix_a_rd;
  logic [pix_aw-1:0]  pix_a_addr;
  logic [15:0]        pix_a_data = '0;
  logic               pix_b_rd;
  logic [pix_aw-1:0]  pix_b_addr;
  logic [15:0]        pix_b_data = '0;
  logic               casc_rd;
  logic [casc_aw-1:0] casc_addr;
  logic [31:0]        casc_data = '0;

  logic [15:0] img_mem  [0:(1 << pix_aw) - 1];
  logic [31:0] casc_mem [0:(1 << casc_aw) - 1];

  int      seed = 84;
  int      errors = 0;
  int      windows_done = 0;
  int      tests_run = 0;
  int      cycles = 0;
  result_t exp_q[$];   // expected results in start order
  string   name_q[$];

  `include "face_ref.svh"

  always #5 ACLK = ~ACLK;

  face_detect_top dut_i (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .start      (start),
    .window     (window),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .pix_a_rd   (pix_a_rd),
    .pix_a_addr (pix_a_addr),
    .pix_a_data (pix_a_data),
    .pix_b_rd   (pix_b_rd),
    .pix_b_addr (pix_b_addr),
    .pix_b_data (pix_b_data),
    .casc_rd    (casc_rd),
    .casc_addr  (casc_addr),
    .casc_data  (casc_data)
  );

  // synchronous memories, one cycle read latency
  always @(posedge ACLK) begin
    if (pix_a_rd) pix_a_data <= img_mem[pix_a_addr];
    if (pix_b_rd) pix_b_data <= img_mem[pix_b_addr];
    if (casc_rd) casc_data <= casc_mem[casc_addr];
  end

  // checks every done against the reference result
  always @(negedge ACLK) begin
    result_t exp_r;
    string   nm;
    if (ARESETN && done) begin
      windows_done++;
      assert (exp_q.size() > 0) else begin
        $display("done strobe arrived with no window waiting for a result");
        errors++;
      end
      if (exp_q.size() > 0) begin
        exp_r = exp_q.pop_front();
        nm    = name_q.pop_front();
        assert (result == exp_r) else begin
          $display(
            "FAILED %s: expected detected=%0b confidence=%0d, actual detected=%0b confidence=%0d",
            nm, exp_r.detected, exp_r.confidence, result.detected, result.confidence);
          errors++;
        end
      end
    end
  end

  always @(posedge ACLK) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic window_t make_window(input int row, input int col, input int size);
    window_t w;
    w.row  = 8'(row);
    w.col  = 8'(col);
    w.size = 16'(size);
    return w;
  endfunction

  task automatic random_inside_window(output window_t w);
    do begin
      w.row  = 8'({$random(seed)} % img_rows);
      w.col  = 8'({$random(seed)} % img_cols);
      w.size = 16'(2 + {$random(seed)} % 40);
    end while (!window_inside(w));
  endtask

  // one window from start strobe to done, latency counted in cycles
  task automatic drive_window(input window_t w, input string name, output int latency,
                              output bit pix_seen, output result_t actual);
    @(negedge ACLK);
    exp_q.push_back(ref_eval(w));
    name_q.push_back(name);
    window   = w;
    start    = 1'b1;
    latency  = 0;
    pix_seen = 1'b0;
    do begin
      @(negedge ACLK);
      start = 1'b0;
      latency++;
      if (pix_a_rd || pix_b_rd) pix_seen = 1'b1;
    end while (!done);
    actual = result;
  endtask

  task automatic check_oob(input window_t w, input string name);
    int      lat;
    bit      pix_seen;
    result_t actual;
    drive_window(w, name, lat, pix_seen, actual);
    assert (lat == 2) else begin
      $display("FAILED %s: expected latency 2, actual %0d", name, lat);
      errors++;
    end
    assert (!pix_seen) else begin
      $display("image read during out-of-bounds window %s", name);
      errors++;
    end
  endtask

  task automatic idle_check(input string phase);
    @(negedge ACLK);
    assert (!busy && !done && !pix_a_rd && !pix_b_rd && !casc_rd) else begin
      $display("strobe or busy high %s", phase);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    @(posedge ACLK);  // compare process has seen the last done
    tests_run++;
    if (errors == errors_before) $display("test %s: passed", name);
    else $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  initial begin
    window_t w;
    window_t w2;
    result_t actual;
    int      lat;
    int      e0;
    int      extra;
    bit      pix_seen;
    ACLK    = 1'b0;
    ARESETN = 1'b0;
    start   = 1'b0;
    window  = '0;
    fill_image();
    fill_cascade();

    e0 = errors;
    repeat (reset_cycles) idle_check("during reset");
    ARESETN = 1'b1;
    repeat (5) idle_check("after reset with no window");
    finish_test("reset", e0);

    e0 = errors;
    check_oob(make_window(3, 32, 8), "oob_top");
    check_oob(make_window(45, 32, 8), "oob_bottom");
    check_oob(make_window(24, 2, 6), "oob_left");
    check_oob(make_window(24, 62, 6), "oob_right");
    check_oob(make_window(24, 32, 100), "oob_large");
    check_oob(make_window(24, 32, 16'hffff), "oob_huge");
    finish_test("out_of_bounds", e0);

    e0 = errors;
    set_thresholds(32'sh8000_0000);
    repeat (4) begin
      random_inside_window(w);
      drive_window(w, "all_pass", lat, pix_seen, actual);
      assert (actual.detected) else begin
        $display("FAILED all_pass: expected detected=1, actual detected=0");
        errors++;
      end
    end
    finish_test("all_pass", e0);

    e0 = errors;
    casc_mem[thr_base] = 32'sh7fff_ffff;  // first tree rejects everything
    repeat (3) begin
      random_inside_window(w);
      drive_window(w, "first_reject", lat, pix_seen, actual);
      assert (!actual.detected && actual.confidence == 0) else begin
        $display(
          "FAILED %s: expected detected=0 confidence=0, actual detected=%0b confidence=%0d",
          "first_reject", actual.detected, actual.confidence);
        errors++;
      end
    end
    finish_test("first_reject", e0);

    e0 = errors;
    fill_image();
    fill_cascade();
    repeat (30) begin
      random_inside_window(w);
      drive_window(w, "random", lat, pix_seen, actual);
    end
    finish_test("random", e0);

    // second start lands while the first window is still running
    e0 = errors;
    random_inside_window(w);
    random_inside_window(w2);
    @(negedge ACLK);
    exp_q.push_back(ref_eval(w));
    name_q.push_back("busy_ignore");
    window = w;
    start  = 1'b1;
    repeat (3) begin
      @(negedge ACLK);
      start = 1'b0;
    end
    assert (busy) else begin
      $display("busy low when the second start was given");
      errors++;
    end
    window = w2;
    start  = 1'b1;
    @(negedge ACLK);
    start = 1'b0;
    while (!done) @(negedge ACLK);
    extra = 0;
    repeat (n_trees * 60) begin  // longer than any full window
      @(negedge ACLK);
      if (done) extra++;
    end
    assert (extra == 0) else begin
      $display("FAILED busy_ignore: expected 0 further done strobes, actual %0d", extra);
      errors++;
    end
    finish_test("busy_ignore", e0);

    assert (exp_q.size() == 0) else begin
      $display("%0d windows never produced a result", exp_q.size());
      errors++;
    end
    $display("tests %0d, windows %0d, errors %0d", tests_run, windows_done, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+bench
rtl/face_pkg.sv
rtl/pixel_lane.sv
rtl/tree_walker.sv
rtl/cascade_ctrl.sv
rtl/face_detect_top.sv
bench/tb_face_detect.sv

/* rtl/cascade_ctrl.sv */
// cascade controller
// bounds check, tree sequencing, confidence accumulation and the final decision
`default_nettype none

module cascade_ctrl import face_pkg::*; (
  input  logic               ACLK,
  input  logic               ARESETN,
  input  logic               start,
  input  window_t            window,
  output logic               busy,
  output logic               tree_go,
  output logic [casc_aw-1:0] tree_base,
  output conf_t              centre_row,
  output conf_t              centre_col,
  output logic [15:0]        size,
  input  logic               tree_done,
  input  tree_out_t          tree_out,
  output logic               done,
  output result_t            result
);

  typedef enum logic [1:0] {
    C_IDLE,
    C_CHECK,
    C_RUN
  } cstate_t;

  cstate_t                    state;
  window_t                    win_q;
  conf_t                      conf;      // running confidence
  logic [$clog2(n_trees)-1:0] tree_cnt;
  conf_t                      half;      // half window, scaled by 256
  logic                       out_of_bounds;
  conf_t                      sum;
  logic                       reject;
  logic                       last_tree;
  logic                       accept;

  assign busy   = state != C_IDLE;
  assign accept = start && !busy;

  assign centre_row = {16'd0, win_q.row, 8'd0};
  assign centre_col = {16'd0, win_q.col, 8'd0};
  assign size       = win_q.size;
  assign half       = {9'd0, win_q.size, 7'd0};
  assign tree_base  = casc_aw'(tree_cnt * tree_stride);

  assign out_of_bounds = (centre_row - half < 0) || (centre_row + half > img_rows * 256 - 1) ||
                         (centre_col - half < 0) || (centre_col + half > img_cols * 256 - 1);

  assign sum       = conf + tree_out.lut;
  assign reject    = sum <= tree_out.thr;
  assign last_tree = tree_cnt == ($clog2(n_trees))'(n_trees - 1);

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      state    <= C_IDLE;
      tree_go  <= 1'b0;
      done     <= 1'b0;
      tree_cnt <= '0;
    end else begin
      tree_go <= 1'b0;
      done    <= 1'b0;
      case (state)
        C_IDLE: if (accept) state <= C_CHECK;
        C_CHECK: begin
          if (out_of_bounds) begin
            done  <= 1'b1;  // rejected without touching memory
            state <= C_IDLE;
          end else begin
            tree_cnt <= '0;
            tree_go  <= 1'b1;
            state    <= C_RUN;
          end
        end
        C_RUN: if (tree_done) begin
          if (reject || last_tree) begin
            done  <= 1'b1;
            state <= C_IDLE;
          end else begin
            tree_cnt <= tree_cnt + 1'b1;
            tree_go  <= 1'b1;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (accept) begin
      win_q <= window;
    end
    if (state == C_CHECK) begin
      conf              <= '0;
      result.detected   <= 1'b0;
      result.confidence <= '0;
    end
    if (state == C_RUN && tree_done) begin
      conf <= sum;
      if (reject) begin
        result.detected   <= 1'b0;
        result.confidence <= '0;
      end else if (last_tree) begin
        result.detected   <= 1'b1;
        result.confidence <= sum - tree_out.thr;  // margin over the last threshold
      end
    end
  end

  // walker may only answer a tree this controller started
  a_no_stray_tree_done: assert property (
    @(posedge ACLK) disable iff (!ARESETN)
    tree_done |-> (state == C_RUN))
    else $error("tree_done with no tree running");

endmodule

`default_nettype wire

/* rtl/face_detect_top.sv */
// face detector top
// cascade controller and tree walker with the image and cascade memory ports
`default_nettype none

module face_detect_top import face_pkg::*; (
  input  logic               ACLK,
  input  logic               ARESETN,
  input  logic               start,
  input  window_t            window,
  output logic               busy,
  output logic               done,
  output result_t            result,
  output logic               pix_a_rd,
  output logic [pix_aw-1:0]  pix_a_addr,
  input  logic [15:0]        pix_a_data,
  output logic               pix_b_rd,
  output logic [pix_aw-1:0]  pix_b_addr,
  input  logic [15:0]        pix_b_data,
  output logic               casc_rd,
  output logic [casc_aw-1:0] casc_addr,
  input  logic [31:0]        casc_data
);

  logic               tree_go;
  logic [casc_aw-1:0] tree_base;
  conf_t              centre_row;
  conf_t              centre_col;
  logic [15:0]        size;
  logic               tree_done;
  tree_out_t          tree_out;

  cascade_ctrl ctrl_i (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .start      (start),
    .window     (window),
    .busy       (busy),
    .tree_go    (tree_go),
    .tree_base  (tree_base),
    .centre_row (centre_row),
    .centre_col (centre_col),
    .size       (size),
    .tree_done  (tree_done),
    .tree_out   (tree_out),
    .done       (done),
    .result     (result)
  );

  tree_walker walker_i (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .tree_go    (tree_go),
    .tree_base  (tree_base),
    .centre_row (centre_row),
    .centre_col (centre_col),
    .size       (size),
    .casc_rd    (casc_rd),
    .casc_addr  (casc_addr),
    .casc_data  (casc_data),
    .pix_a_rd   (pix_a_rd),
    .pix_a_addr (pix_a_addr),
    .pix_a_data (pix_a_data),
    .pix_b_rd   (pix_b_rd),
    .pix_b_addr (pix_b_addr),
    .pix_b_data (pix_b_data),
    .tree_done  (tree_done),
    .tree_out   (tree_out)
  );

endmodule

`default_nettype wire

/* rtl/face_pkg.sv */
// face detector package
// image and cascade geometry, shared structs and the gray conversion
`default_nettype none

package face_pkg;

  // image geometry
  localparam int img_rows = 48;
  localparam int img_cols = 64;

  // cascade layout, all in 32-bit words
  localparam int tree_depth  = 6;
  localparam int n_trees     = 16;
  localparam int tree_stride = 128;
  localparam int lut_base    = 63;   // first leaf value of a tree
  localparam int thr_base    = 127;  // threshold word of a tree

  localparam int pix_aw  = 12;
  localparam int casc_aw = 11;

  // one detection window
  typedef struct packed {
    logic [7:0]  row;
    logic [7:0]  col;
    logic [15:0] size;
  } window_t;

  // node code, r1 sits in the top byte
  typedef struct packed {
    logic signed [7:0] r1;
    logic signed [7:0] c1;
    logic signed [7:0] r2;
    logic signed [7:0] c2;
  } tcode_t;

  typedef logic signed [31:0] conf_t;  // fixed-point confidence

  typedef struct packed {
    conf_t lut;
    conf_t thr;
  } tree_out_t;

  typedef struct packed {
    logic  detected;
    conf_t confidence;
  } result_t;

  // rgb565 to 8-bit gray, weights sum to 256
  function automatic logic [7:0] rgb565_gray(input logic [15:0] px);
    logic [15:0] acc;
    acc = 16'(px[15:11]) * 16'd76 + 16'(px[10:5]) * 16'd150 + 16'(px[4:0]) * 16'd30;
    return acc[15:8];
  endfunction

endpackage

`default_nettype wire

/* rtl/pixel_lane.sv */
// pixel lane
// scales a node offset into an image address, reads the pixel, returns its gray value
`default_nettype none

module pixel_lane import face_pkg::*; (
  input  logic              ACLK,
  input  logic              ARESETN,
  input  logic              fetch,
  input  conf_t             centre_row,
  input  conf_t             centre_col,
  input  logic [15:0]       size,
  input  logic signed [7:0] dr,
  input  logic signed [7:0] dc,
  output logic              pix_rd,
  output logic [pix_aw-1:0] pix_addr,
  input  logic [15:0]       pix_data,
  output logic              gray_valid,
  output logic [7:0]        gray
);

  logic signed [16:0] size_s;  // size as a positive signed operand
  conf_t              row_full;
  conf_t              col_full;
  conf_t              row_q;
  conf_t              col_q;
  logic               rd_q;    // read data present this cycle

  assign size_s   = {1'b0, size};
  assign row_full = centre_row + dr * size_s;
  assign col_full = centre_col + dc * size_s;

  assign pix_addr = pix_aw'(row_q * img_cols + col_q);

  // three stage strobe pipe: address, memory, conversion
  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      pix_rd     <= 1'b0;
      rd_q       <= 1'b0;
      gray_valid <= 1'b0;
    end else begin
      pix_rd     <= fetch;
      rd_q       <= pix_rd;
      gray_valid <= rd_q;
    end
  end

  always_ff @(posedge ACLK) begin
    if (fetch) begin
      row_q <= row_full >>> 8;  // back to pixel units
      col_q <= col_full >>> 8;
    end
    if (rd_q) begin
      gray <= rgb565_gray(pix_data);
    end
  end

  // bounds check upstream must keep every node pixel inside the image
  a_pix_in_image: assert property (
    @(posedge ACLK) disable iff (!ARESETN)
    pix_rd |-> (row_q >= 0 && row_q < img_rows && col_q >= 0 && col_q < img_cols))
    else $error("pixel lane read outside the image");

endmodule

`default_nettype wire

/* rtl/tree_walker.sv */
// tree walker
// walks one depth-6 tree with two pixel lanes, then reads its leaf value and threshold
`default_nettype none

module tree_walker import face_pkg::*; (
  input  logic               ACLK,
  input  logic               ARESETN,
  input  logic               tree_go,
  input  logic [casc_aw-1:0] tree_base,
  input  conf_t              centre_row,
  input  conf_t              centre_col,
  input  logic [15:0]        size,
  output logic               casc_rd,
  output logic [casc_aw-1:0] casc_addr,
  input  logic [31:0]        casc_data,
  output logic               pix_a_rd,
  output logic [pix_aw-1:0]  pix_a_addr,
  input  logic [15:0]        pix_a_data,
  output logic               pix_b_rd,
  output logic [pix_aw-1:0]  pix_b_addr,
  input  logic [15:0]        pix_b_data,
  output logic               tree_done,
  output tree_out_t          tree_out
);

  typedef enum logic [2:0] {
    W_IDLE,
    W_CODE_RD,
    W_CODE_TAKE,
    W_GRAY,
    W_LUT_RD,
    W_LUT_TAKE,
    W_THR_TAKE
  } wstate_t;

  wstate_t            state;
  logic [casc_aw-1:0] base_q;
  logic [6:0]         idx;      // heap index, leaves land in 64..127
  logic [6:0]         next_idx;
  logic [2:0]         level;
  logic               last_level;
  tcode_t             tcode_q;
  logic               fetch;
  logic               gray_a_valid;
  logic [7:0]         gray_a;
  logic [7:0]         gray_b;

  assign next_idx   = {idx[5:0], gray_a <= gray_b};
  assign last_level = level == 3'(tree_depth - 1);

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      state     <= W_IDLE;
      casc_rd   <= 1'b0;
      fetch     <= 1'b0;
      tree_done <= 1'b0;
      idx       <= 7'd1;
      level     <= '0;
    end else begin
      tree_done <= 1'b0;
      case (state)
        W_IDLE: if (tree_go) begin
          casc_rd <= 1'b1;  // first node code
          idx     <= 7'd1;
          level   <= '0;
          state   <= W_CODE_RD;
        end
        W_CODE_RD: begin
          casc_rd <= 1'b0;
          state   <= W_CODE_TAKE;
        end
        W_CODE_TAKE: begin
          fetch <= 1'b1;
          state <= W_GRAY;
        end
        W_GRAY: begin
          fetch <= 1'b0;
          if (gray_a_valid) begin  // lane b finishes in the same cycle
            idx     <= next_idx;
            level   <= level + 3'd1;
            casc_rd <= 1'b1;
            state   <= last_level ? W_LUT_RD : W_CODE_RD;
          end
        end
        W_LUT_RD: state <= W_LUT_TAKE;  // rd held for the threshold word
        W_LUT_TAKE: begin
          casc_rd <= 1'b0;
          state   <= W_THR_TAKE;
        end
        W_THR_TAKE: begin
          tree_done <= 1'b1;
          state     <= W_IDLE;
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    case (state)
      W_IDLE: if (tree_go) begin
        base_q    <= tree_base;
        casc_addr <= tree_base;
      end
      W_CODE_TAKE: tcode_q <= tcode_t'(casc_data);
      W_GRAY: if (gray_a_valid) begin
        if (last_level) casc_addr <= base_q + casc_aw'(lut_base + int'(next_idx) - 64);
        else            casc_addr <= base_q + casc_aw'(next_idx - 7'd1);
      end
      W_LUT_RD:   casc_addr    <= base_q + casc_aw'(thr_base);
      W_LUT_TAKE: tree_out.lut <= casc_data;
      W_THR_TAKE: tree_out.thr <= casc_data;
      default: ;
    endcase
  end

  pixel_lane lane_a_i (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .fetch      (fetch),
    .centre_row (centre_row),
    .centre_col (centre_col),
    .size       (size),
    .dr         (tcode_q.r1),
    .dc         (tcode_q.c1),
    .pix_rd     (pix_a_rd),
    .pix_addr   (pix_a_addr),
    .pix_data   (pix_a_data),
    .gray_valid (gray_a_valid),
    .gray       (gray_a)
  );

  pixel_lane lane_b_i (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .fetch      (fetch),
    .centre_row (centre_row),
    .centre_col (centre_col),
    .size       (size),
    .dr         (tcode_q.r2),
    .dc         (tcode_q.c2),
    .pix_rd     (pix_b_rd),
    .pix_addr   (pix_b_addr),
    .pix_data   (pix_b_data),
    .gray_valid (),
    .gray       (gray_b)
  );

  // after six levels the index must sit in the leaf row
  a_leaf_idx: assert property (
    @(posedge ACLK) disable iff (!ARESETN)
    (state == W_LUT_RD) |-> (idx >= 7'd64 && idx <= 7'd127))
    else $error("leaf index out of range");

endmodule

`default_nettype wire
